//--- all.f
+incdir+.
ctrl_pkg.sv
instrClassifier.sv
aluSteering.sv
accessStrobes.sv
mipsControl.sv
tbClock.sv
mipsControl_chk.sv
mipsControl_tb.sv

//--- mipsControl_tb.sv
`timescale 1ns/10ps

module mipsControl_tb;
    import ctrlPkg::*;

    localparam int          resetCycles = 10;
    localparam logic [31:0] rMask   = 32'h03FF_FFC0;  // rs, rt, rd, shamt.
    localparam logic [31:0] iMask   = 32'h03E0_FFFF;  // rs and imm.
    localparam logic [31:0] jMask   = 32'h03FF_FFFF;
    localparam logic [31:0] anyMask = 32'hFFFF_FFFF;

    typedef struct {
        int          testId;
        cpuState_t   st;
        logic [31:0] base;
        logic [31:0] mask;
        aluCtrl_t    expAlu;
        accessCtrl_t expAcc;
    } tableRow_t;

    logic        clk;
    logic        rst;
    cpuState_t   state;
    instrWord_u  instr;
    aluCtrl_t    aluCtrl;
    accessCtrl_t accessCtrl;

    tableRow_t   rowQ[$];
    int          curTest = 0;
    int          checks = 0;
    int          errors = 0;
    int          testErrors = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'hccd7_542f;

    tbClock #(.periodNs(4.0)) clkGen (.clk(clk));

    mipsControl uut (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .instr      (instr),
        .aluCtrl    (aluCtrl),
        .accessCtrl (accessCtrl)
    );

    // ############################
    // helpers.
    // ############################

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string testName(input int id);
        case (id)
            0:       return "reset";
            1:       return "fetch";
            2:       return "rtype";
            3:       return "load/store";
            4:       return "branch/jump";
            default: return "class hold";
        endcase
    endfunction

    function automatic aluCtrl_t aluWord(aluOp_t op, logic [1:0] a, logic [2:0] b,
                                         extMode_t ext, logic swap);
        return '{aluOp: op, srcA: a, srcB: b, extMode: ext, abSwap: swap};
    endfunction

    function automatic accessCtrl_t accFetch();
        return '{irWrite: 1, memRead: 1, pcWrite: 1, default: 0};
    endfunction

    function automatic accessCtrl_t accDec(logic [1:0] rd, logic apw);
        return '{pcSrc: 2, memRead: 1, altPcMux: 1, regDst: rd, altPcWrite: apw,
                 default: 0};
    endfunction

    function automatic accessCtrl_t accExe(logic [1:0] rd, logic apw, logic li);
        return '{pcSrc: 1, memRead: 1, altPcMux: 1, linkEn: 1, regDst: rd,
                 altPcWrite: apw, linkIn: li, default: 0};
    endfunction

    function automatic accessCtrl_t accMem(logic [1:0] m2r, logic [1:0] rd, logic [1:0] ad,
                                           logic st, logic rw, logic apw, logic [1:0] bc);
        return '{memToReg: m2r, regDst: rd, iorD: ad, memWrite: st, memRead: !st,
                 regWrite: rw, altPcWrite: apw, byteCnt: bc, default: 0};
    endfunction

    function automatic accessCtrl_t accLw(logic rw, logic [2:0] mc);
        return '{memToReg: 1, pcSrc: 2, memRead: 1, altPcMux: 1, regWrite: rw,
                 maskCnt: mc, default: 0};
    endfunction

    task automatic addRow(cpuState_t st, logic [31:0] base, logic [31:0] mask,
                          aluCtrl_t a, accessCtrl_t c);
        tableRow_t r;
        r.testId = curTest;
        r.st     = st;
        r.base   = base;
        r.mask   = mask;
        r.expAlu = a;
        r.expAcc = c;
        rowQ.push_back(r);
    endtask

    // ############################
    // stimulus table.
    // ############################

    task automatic buildTable();
        curTest = 1;  // class is still nop after reset.
        addRow(fetch, 32'h0, anyMask, aluWord(aluAdd, 0, 1, zeroExt, 0), accFetch());

        curTest = 2;  // addu, xor, sra, sllv, slt.
        addRow(decode, 32'h00000021, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(1, 0));
        addRow(execute, 32'h00000021, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0), accExe(1, 0, 0));
        addRow(memAccess, 32'h00000021, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 1, 0, 0, 1, 0, 0));
        addRow(decode, 32'h00000026, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(1, 0));
        addRow(execute, 32'h00000026, rMask, aluWord(aluXor, 1, 0, zeroExt, 0), accExe(1, 0, 0));
        addRow(memAccess, 32'h00000026, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 1, 0, 0, 1, 0, 0));
        addRow(decode, 32'h00000003, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(1, 0));
        addRow(execute, 32'h00000003, rMask, aluWord(aluSra, 1, 4, zeroExt, 1), accExe(1, 0, 0));
        addRow(memAccess, 32'h00000003, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 1, 0, 0, 1, 0, 0));
        addRow(decode, 32'h00000004, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(1, 0));
        addRow(execute, 32'h00000004, rMask, aluWord(aluSll, 1, 5, zeroExt, 1), accExe(1, 0, 0));
        addRow(memAccess, 32'h00000004, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 1, 0, 0, 1, 0, 0));
        addRow(decode, 32'h0000002A, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(1, 0));
        addRow(execute, 32'h0000002A, rMask, aluWord(aluSub, 1, 0, zeroExt, 0), accExe(1, 0, 0));
        addRow(memAccess, 32'h0000002A, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(2, 1, 0, 0, 1, 0, 0));

        curTest = 3;
        addRow(decode, 32'h8C000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(memAccess, 32'h8C000000, iMask, aluWord(aluAdd, 1, 0, signExt, 0),
               accMem(0, 0, 1, 0, 0, 0, 0));
        addRow(loadWrite, 32'h8C000000, iMask, aluWord(aluAdd, 0, 1, signExt, 0), accLw(1, 0));
        addRow(decode, 32'h80000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(loadWrite, 32'h80000000, iMask, aluWord(aluAdd, 0, 1, signExt, 0), accLw(1, 3));
        addRow(decode, 32'h90000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(loadWrite, 32'h90000000, iMask, aluWord(aluAdd, 0, 1, signExt, 0), accLw(1, 4));
        addRow(decode, 32'h84000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(loadWrite, 32'h84000000, iMask, aluWord(aluAdd, 0, 1, signExt, 0), accLw(1, 1));
        addRow(decode, 32'h94000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(loadWrite, 32'h94000000, iMask, aluWord(aluAdd, 0, 1, signExt, 0), accLw(1, 2));
        addRow(decode, 32'hAC000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(memAccess, 32'hAC000000, iMask, aluWord(aluAdd, 1, 0, signExt, 0),
               accMem(0, 0, 1, 1, 0, 0, 0));
        addRow(decode, 32'hA0000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(memAccess, 32'hA0000000, iMask, aluWord(aluAdd, 1, 0, signExt, 0),
               accMem(0, 0, 1, 1, 0, 0, 1));
        addRow(decode, 32'hA4000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(memAccess, 32'hA4000000, iMask, aluWord(aluAdd, 1, 0, signExt, 0),
               accMem(0, 0, 1, 1, 0, 0, 2));

        curTest = 4;  // beq, bgtz, j, jal, jr, jalr, lui, andi.
        addRow(decode, 32'h10000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(execute, 32'h10000000, iMask, aluWord(aluSub, 1, 0, signExt, 0), accExe(0, 1, 0));
        addRow(decode, 32'h1C000000, iMask, aluWord(aluAdd, 0, 3, signExt, 0), accDec(0, 0));
        addRow(execute, 32'h1C000000, iMask, aluWord(aluSub, 1, 0, signExt, 0), accExe(0, 1, 0));
        addRow(decode, 32'h08000000, jMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(0, 1));
        addRow(decode, 32'h0C000000, jMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(2, 1));
        addRow(execute, 32'h0C000000, jMask, aluWord(aluAdd, 1, 0, zeroExt, 0), accExe(0, 0, 1));
        addRow(decode, 32'h00000008, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(1, 0));
        addRow(memAccess, 32'h00000008, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 1, 0, 0, 0, 1, 0));
        addRow(decode, 32'h00000009, rMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(2, 0));
        addRow(execute, 32'h00000009, rMask, aluWord(aluAdd, 1, 6, zeroExt, 0), accExe(1, 0, 1));
        addRow(memAccess, 32'h00000009, rMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 1, 0, 0, 0, 1, 0));
        addRow(decode, 32'h3C000000, iMask, aluWord(aluAdd, 0, 3, upperExt, 0), accDec(0, 0));
        addRow(execute, 32'h3C000000, iMask, aluWord(aluAdd, 2, 2, upperExt, 0), accExe(0, 0, 0));
        addRow(memAccess, 32'h3C000000, iMask, aluWord(aluAdd, 1, 0, upperExt, 0),
               accMem(0, 0, 0, 0, 1, 0, 0));
        addRow(decode, 32'h30000000, iMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(0, 0));
        addRow(execute, 32'h30000000, iMask, aluWord(aluAnd, 1, 2, zeroExt, 0), accExe(0, 0, 0));

        curTest = 5;  // ori held, then an undefined opcode.
        addRow(decode, 32'h34000000, iMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(0, 0));
        addRow(execute, 32'h0, anyMask, aluWord(aluOr, 1, 2, zeroExt, 0), accExe(0, 0, 0));
        addRow(memAccess, 32'h0, anyMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 0, 0, 0, 1, 0, 0));
        addRow(decode, 32'hFC000000, jMask, aluWord(aluAdd, 0, 3, zeroExt, 0), accDec(0, 0));
        addRow(execute, 32'h0, anyMask, aluWord(aluAdd, 1, 0, zeroExt, 0), accExe(0, 0, 0));
        addRow(memAccess, 32'h0, anyMask, aluWord(aluAdd, 1, 0, zeroExt, 0),
               accMem(0, 0, 0, 0, 0, 0, 0));
        addRow(halt, 32'h0, anyMask, aluWord(aluAdd, 0, 1, zeroExt, 0), '0);
        addRow(fetch, 32'h0, anyMask, aluWord(aluAdd, 0, 1, zeroExt, 0), accFetch());
    endtask

    // ############################
    // checks and report.
    // ############################

    task automatic reportTest(input int id);
        $display("test %s finished, %0d mismatches", testName(id), testErrors);
        testErrors = 0;
    endtask

    task automatic checkRow(input int idx);
        tableRow_t r;
        r = rowQ[idx];
        checks++;
        if (aluCtrl !== r.expAlu) begin
            $display("Mismatch aluCtrl row %0d: expected %h, got %h", idx, r.expAlu, aluCtrl);
            errors++;
            testErrors++;
        end
        if (accessCtrl !== r.expAcc) begin
            $display("Mismatch accessCtrl row %0d: expected %h, got %h",
                     idx, r.expAcc, accessCtrl);
            errors++;
            testErrors++;
        end
        if (idx == rowQ.size() - 1 || rowQ[idx + 1].testId != r.testId) begin
            reportTest(r.testId);  // last row of this test.
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= resetCycles + 2 * rowQ.size() + 50) begin
            $display("Timeout: the table did not finish within %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst   = 1'b1;
        state = fetch;
        instr = '0;
        buildTable();

        repeat (resetCycles - 1) @(posedge clk);
        @(negedge clk);
        checks++;
        if (aluCtrl !== '0 || accessCtrl !== '0) begin
            $display("Mismatch aluCtrl/accessCtrl after reset: expected 0, got %h/%h",
                     aluCtrl, accessCtrl);
            errors++;
            testErrors++;
        end
        reportTest(0);
        @(posedge clk);
        rst <= 1'b0;

        // row i is driven here and checked one edge later.
        for (int i = 0; i <= rowQ.size(); i++) begin
            @(posedge clk);
            if (i < rowQ.size()) begin
                rng = nextRandom(rng);
                state <= rowQ[i].st;
                instr <= (rowQ[i].base & ~rowQ[i].mask) | (rng & rowQ[i].mask);
            end
            @(negedge clk);
            if (i > 0) begin
                checkRow(i - 1);
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mipsControl_chk.sv
`timescale 1ns/10ps

module mipsControl_chk (
    input logic                  clk,
    input logic                  rst,
    input ctrlPkg::cpuState_t    state,
    input ctrlPkg::accessCtrl_t  accessCtrl
);
    import ctrlPkg::*;

    // memory port is read or write, never both.
    memExclusive: assert property (@(posedge clk) disable iff (rst)
        !(accessCtrl.memWrite && accessCtrl.memRead))
        else $error("memWrite and memRead are high together");

    irWriteAfterFetch: assert property (@(posedge clk) disable iff (rst)
        state != fetch |=> !accessCtrl.irWrite)
        else $error("irWrite is high without a fetch one cycle before");

    idleAfterHalt: assert property (@(posedge clk) disable iff (rst)
        state == halt |=> accessCtrl == '0)
        else $error("a strobe is active one cycle after halt");

endmodule

bind accessStrobes mipsControl_chk chk (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .accessCtrl (accessCtrl)
);

//--- tbClock.sv
`timescale 1ns/10ps

module tbClock #(
    parameter real periodNs = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2.0) clk = ~clk;  // free running.
        end
    end

endmodule

//--- mipsControl.sv
`timescale 1ns/10ps

module mipsControl (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrlPkg::cpuState_t      state,
    input  ctrlPkg::instrWord_u     instr,
    output ctrlPkg::aluCtrl_t       aluCtrl,
    output ctrlPkg::accessCtrl_t    accessCtrl
);
    import ctrlPkg::*;

    instrClass_t cls;  // held after decode.

    instrClassifier classifier (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .instr (instr),
        .cls   (cls)
    );

    aluSteering steering (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .cls     (cls),
        .aluCtrl (aluCtrl)
    );

    accessStrobes strobes (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .cls        (cls),
        .accessCtrl (accessCtrl)
    );

endmodule

//--- accessStrobes.sv
`timescale 1ns/10ps

module accessStrobes (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrlPkg::cpuState_t      state,
    input  ctrlPkg::instrClass_t    cls,
    output ctrlPkg::accessCtrl_t    accessCtrl
);
    import ctrlPkg::*;

    accessCtrl_t nextCtrl;

    always_comb begin
        nextCtrl = '0;
        case (state)
            fetch: begin
                nextCtrl.irWrite = 1'b1;
                nextCtrl.memRead = 1'b1;
                nextCtrl.pcWrite = 1'b1;
            end

            // ############################
            // decode and execute.
            // ############################
            decode: begin
                nextCtrl.pcSrc      = 2'd2;
                nextCtrl.memRead    = 1'b1;
                nextCtrl.altPcMux   = 1'b1;
                nextCtrl.altPcWrite = cls inside {clsJ, clsJal};  // jump target.
                if (cls inside {clsJal, clsJalr}) begin
                    nextCtrl.regDst = 2'd2;  // link register.
                end else if (isRtype(cls)) begin
                    nextCtrl.regDst = 2'd1;
                end
            end
            execute: begin
                nextCtrl.pcSrc      = 2'd1;
                nextCtrl.memRead    = 1'b1;
                nextCtrl.altPcMux   = 1'b1;
                nextCtrl.linkEn     = 1'b1;
                nextCtrl.altPcWrite = isBranch(cls);
                nextCtrl.linkIn     = cls inside {clsJal, clsJalr};
                if (isRtype(cls)) begin
                    nextCtrl.regDst = 2'd1;
                end
            end

            // ############################
            // memory and write back.
            // ############################
            memAccess: begin
                if (isSltFam(cls)) begin
                    nextCtrl.memToReg = 2'd2;  // compare flag.
                end
                if (isRtype(cls)) begin
                    nextCtrl.regDst = 2'd1;
                end
                if (isLoad(cls) || isStore(cls)) begin
                    nextCtrl.iorD = 2'd1;  // data address.
                end
                nextCtrl.memWrite   = isStore(cls);
                nextCtrl.memRead    = !isStore(cls);
                nextCtrl.regWrite   = isRAlu(cls) || isImm(cls);
                nextCtrl.altPcWrite = cls inside {clsJr, clsJalr};
                case (cls)
                    clsSb:   nextCtrl.byteCnt = 2'd1;
                    clsSh:   nextCtrl.byteCnt = 2'd2;
                    default: nextCtrl.byteCnt = 2'd0;
                endcase
            end
            loadWrite: begin
                nextCtrl.memToReg = 2'd1;
                nextCtrl.pcSrc    = 2'd2;
                nextCtrl.memRead  = 1'b1;
                nextCtrl.altPcMux = 1'b1;
                nextCtrl.regWrite = isLoad(cls);
                case (cls)  // sub-word load masks.
                    clsLh:   nextCtrl.maskCnt = 3'd1;
                    clsLhu:  nextCtrl.maskCnt = 3'd2;
                    clsLb:   nextCtrl.maskCnt = 3'd3;
                    clsLbu:  nextCtrl.maskCnt = 3'd4;
                    default: nextCtrl.maskCnt = 3'd0;
                endcase
            end
            default: begin
                nextCtrl = '0;  // halt, everything idle.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accessCtrl <= '0;
        end else begin
            accessCtrl <= nextCtrl;
        end
    end

endmodule

//--- aluSteering.sv
`timescale 1ns/10ps

module aluSteering (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrlPkg::cpuState_t      state,
    input  ctrlPkg::instrClass_t    cls,
    output ctrlPkg::aluCtrl_t       aluCtrl
);
    import ctrlPkg::*;

    aluCtrl_t nextCtrl;

    always_comb begin
        nextCtrl = '0;

        // extension is a function of the class alone.
        if (cls == clsLui) begin
            nextCtrl.extMode = upperExt;
        end else if (cls inside {clsAddiu, clsSlti, clsSltiu} ||
                     isLoad(cls) || isStore(cls) || isBranch(cls)) begin
            nextCtrl.extMode = signExt;
        end else begin
            nextCtrl.extMode = zeroExt;
        end

        case (state)
            decode: begin
                nextCtrl.srcB = 3'd3;  // branch target.
            end
            execute: begin
                nextCtrl.srcA = (cls == clsLui) ? 2'd2 : 2'd1;
                if (isImm(cls) || isLoad(cls) || isStore(cls)) begin
                    nextCtrl.srcB = 3'd2;
                end else if (cls inside {clsSll, clsSrl, clsSra}) begin
                    nextCtrl.srcB = 3'd4;  // shamt.
                end else if (cls inside {clsSllv, clsSrlv, clsSrav}) begin
                    nextCtrl.srcB = 3'd5;
                end else if (cls inside {clsJr, clsJalr}) begin
                    nextCtrl.srcB = 3'd6;
                end
                if (isBranch(cls) || isSltFam(cls) || cls == clsSubu) begin
                    nextCtrl.aluOp = aluSub;
                end else begin
                    case (cls)
                        clsAnd, clsAndi:  nextCtrl.aluOp = aluAnd;
                        clsOr, clsOri:    nextCtrl.aluOp = aluOr;
                        clsXor, clsXori:  nextCtrl.aluOp = aluXor;
                        clsSll, clsSllv:  nextCtrl.aluOp = aluSll;
                        clsSrl, clsSrlv:  nextCtrl.aluOp = aluSrl;
                        clsSra, clsSrav:  nextCtrl.aluOp = aluSra;
                        default:          nextCtrl.aluOp = aluAdd;
                    endcase
                end
                nextCtrl.abSwap = cls inside {[clsSll:clsSrav]};
            end
            memAccess: begin
                nextCtrl.srcA = 2'd1;
            end
            default: begin
                nextCtrl.srcB = 3'd1;  // pc plus four.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluCtrl <= '0;
        end else begin
            aluCtrl <= nextCtrl;
        end
    end

endmodule

//--- instrClassifier.sv
`timescale 1ns/10ps

module instrClassifier (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrlPkg::cpuState_t      state,
    input  ctrlPkg::instrWord_u     instr,
    output ctrlPkg::instrClass_t    cls
);
    import ctrlPkg::*;

    instrClass_t fresh;
    instrClass_t held;

    always_comb begin
        fresh = clsNop;
        case (instr.i.opcode)
            6'b000000: begin  // special.
                case (instr.r.funct)
                    6'b100000, 6'b100001: fresh = clsAddu;
                    6'b100010, 6'b100011: fresh = clsSubu;
                    6'b100100: fresh = clsAnd;
                    6'b100101: fresh = clsOr;
                    6'b100110: fresh = clsXor;
                    6'b101010: fresh = clsSlt;
                    6'b101011: fresh = clsSltu;
                    6'b000000: fresh = clsSll;
                    6'b000010: fresh = clsSrl;
                    6'b000011: fresh = clsSra;
                    6'b000100: fresh = clsSllv;
                    6'b000110: fresh = clsSrlv;
                    6'b000111: fresh = clsSrav;
                    6'b001000: fresh = clsJr;
                    6'b001001: fresh = clsJalr;
                    default:   fresh = clsNop;
                endcase
            end
            6'b000001: begin  // regimm, rt picks the branch.
                case (instr.r.rt)
                    5'b00000: fresh = clsBltz;
                    5'b00001: fresh = clsBgez;
                    default:  fresh = clsNop;
                endcase
            end
            6'b000110: fresh = (instr.r.rt == '0) ? clsBlez : clsNop;
            6'b000111: fresh = (instr.r.rt == '0) ? clsBgtz : clsNop;
            6'b000010: fresh = clsJ;
            6'b000011: fresh = clsJal;
            6'b000100: fresh = clsBeq;
            6'b000101: fresh = clsBne;
            6'b001000, 6'b001001: fresh = clsAddiu;
            6'b001010: fresh = clsSlti;
            6'b001011: fresh = clsSltiu;
            6'b001100: fresh = clsAndi;
            6'b001101: fresh = clsOri;
            6'b001110: fresh = clsXori;
            6'b001111: fresh = clsLui;
            6'b100000: fresh = clsLb;
            6'b100001: fresh = clsLh;
            6'b100011: fresh = clsLw;
            6'b100100: fresh = clsLbu;
            6'b100101: fresh = clsLhu;
            6'b101000: fresh = clsSb;
            6'b101001: fresh = clsSh;
            6'b101011: fresh = clsSw;
            default:   fresh = clsNop;
        endcase
    end

    // capture at the decode edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= clsNop;
        end else if (state == decode) begin
            held <= fresh;
        end
    end

    assign cls = (state == decode) ? fresh : held;  // live only in decode.

endmodule

//--- ctrl_pkg.sv
`include "ctrl_params.svh"

package ctrlPkg;

    // ############################
    // sequencer and instruction.
    // ############################

    typedef enum logic [`CTRL_STATE_W-1:0] {
        fetch     = 4'd0,
        decode    = 4'd1,
        execute   = 4'd2,
        memAccess = 4'd3,
        loadWrite = 4'd4,
        halt      = 4'd5
    } cpuState_t;

    typedef struct packed {
        logic [`CTRL_OPCODE_W-1:0] opcode;
        logic [`CTRL_REG_W-1:0]    rs;
        logic [`CTRL_REG_W-1:0]    rt;
        logic [`CTRL_REG_W-1:0]    rd;
        logic [`CTRL_SHAMT_W-1:0]  shamt;
        logic [`CTRL_FUNCT_W-1:0]  funct;
    } rFields_t;

    typedef struct packed {
        logic [`CTRL_OPCODE_W-1:0] opcode;
        logic [`CTRL_REG_W-1:0]    rs;
        logic [`CTRL_REG_W-1:0]    rt;
        logic [`CTRL_IMM_W-1:0]    imm;
    } iFields_t;

    typedef union packed {
        rFields_t r;  // special opcode and regimm branches.
        iFields_t i;
    } instrWord_u;

    typedef enum logic [5:0] {
        clsNop = 6'd0,
        clsAddu, clsSubu, clsAnd, clsOr, clsXor, clsSlt, clsSltu,
        clsSll, clsSrl, clsSra, clsSllv, clsSrlv, clsSrav, clsJr, clsJalr,
        clsAddiu, clsSlti, clsSltiu, clsAndi, clsOri, clsXori, clsLui,
        clsLw, clsLb, clsLbu, clsLh, clsLhu, clsSw, clsSb, clsSh,
        clsBeq, clsBne, clsBgez, clsBltz, clsBgtz, clsBlez, clsJ, clsJal
    } instrClass_t;

    // ############################
    // control words.
    // ############################

    typedef enum logic [`CTRL_ALUOP_W-1:0] {
        aluAdd = 4'd0, aluSub = 4'd1, aluAnd = 4'd2, aluOr = 4'd3,
        aluXor = 4'd4, aluSll = 4'd5, aluSrl = 4'd6, aluSra = 4'd7
    } aluOp_t;

    typedef enum logic [1:0] {
        zeroExt  = 2'd0,
        signExt  = 2'd2,
        upperExt = 2'd3  // imm into the upper half.
    } extMode_t;

    typedef struct packed {
        aluOp_t     aluOp;
        logic [1:0] srcA;
        logic [2:0] srcB;
        extMode_t   extMode;
        logic       abSwap;
    } aluCtrl_t;

    typedef struct packed {
        logic [1:0] regDst;
        logic [1:0] memToReg;
        logic [1:0] pcSrc;
        logic [1:0] iorD;
        logic       irWrite;
        logic       memWrite;
        logic       memRead;
        logic       pcWrite;
        logic       regWrite;
        logic       altPcWrite;
        logic       altPcMux;
        logic       linkEn;
        logic       linkIn;
        logic [1:0] byteCnt;
        logic [2:0] maskCnt;
    } accessCtrl_t;

    // class groups.
    function automatic logic isLoad(instrClass_t c);
        return c inside {clsLw, clsLb, clsLbu, clsLh, clsLhu};
    endfunction

    function automatic logic isStore(instrClass_t c);
        return c inside {clsSw, clsSb, clsSh};
    endfunction

    function automatic logic isBranch(instrClass_t c);
        return c inside {clsBeq, clsBne, clsBgez, clsBltz, clsBgtz, clsBlez};
    endfunction

    function automatic logic isSltFam(instrClass_t c);
        return c inside {clsSlt, clsSltu, clsSlti, clsSltiu};
    endfunction

    function automatic logic isImm(instrClass_t c);
        return c inside {clsAddiu, clsSlti, clsSltiu, clsAndi, clsOri, clsXori, clsLui};
    endfunction

    // special opcode classes, jr and jalr included.
    function automatic logic isRtype(instrClass_t c);
        return c inside {[clsAddu:clsJalr]};
    endfunction

    function automatic logic isRAlu(instrClass_t c);
        return isRtype(c) && !(c inside {clsJr, clsJalr});
    endfunction

endpackage

//--- ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction word fields.
`define CTRL_INSTR_W   32
`define CTRL_OPCODE_W  6
`define CTRL_FUNCT_W   6
`define CTRL_REG_W     5
`define CTRL_SHAMT_W   5
`define CTRL_IMM_W     16

// sequencer state.
`define CTRL_STATE_W   4

// alu operation code.
`define CTRL_ALUOP_W   4

`endif
